//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Baud timing is counted in clock cycles
    typedef logic [15:0] tick_t;
    typedef logic [7:0]  byte_t;
    typedef logic [0:0]  reg_addr_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map and defaults
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam reg_addr_t REG_DIVISOR = 1'b0;
    localparam reg_addr_t REG_CONTROL = 1'b1;

    localparam int CTRL_TX_ENABLE = 0;
    localparam int CTRL_RX_ENABLE = 1;

    localparam tick_t DEFAULT_HALF_BIT_TICKS = 16'd8;
    localparam tick_t MIN_HALF_BIT_TICKS     = 16'd2;

    // Stop bit is slightly shorter than a full bit
    localparam int STOP_NUM = 9;
    localparam int STOP_DEN = 10;

    // Transmitter bit states count up from start through bit 7
    localparam logic [3:0] TX_IDLE  = 4'd0;
    localparam logic [3:0] TX_START = 4'd1;
    localparam logic [3:0] TX_BIT7  = 4'd9;
    localparam logic [3:0] TX_STOP  = 4'd10;

    function automatic tick_t stop_ticks_for(input tick_t half_bit);
        logic [31:0] product;
        product = 32'(half_bit) * 32'(2 * STOP_NUM);
        return tick_t'(product / 32'(STOP_DEN));
    endfunction

endpackage

`default_nettype wire

//--- uart_cfg_if.sv
`default_nettype none

interface uart_cfg_if;
    import uart_pkg::*;

    tick_t half_bit_ticks;
    tick_t bit_ticks;
    tick_t stop_ticks;
    logic  tx_enable;
    logic  rx_enable;

    modport source (
        output half_bit_ticks,
        output bit_ticks,
        output stop_ticks,
        output tx_enable,
        output rx_enable
    );

    modport sink (
        input half_bit_ticks,
        input bit_ticks,
        input stop_ticks,
        input tx_enable,
        input rx_enable
    );

endinterface

`default_nettype wire

//--- uart_cfg_regs.sv
`default_nettype none

module uart_cfg_regs (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                cfg_we,
    input  wire uart_pkg::reg_addr_t cfg_addr,
    input  wire uart_pkg::tick_t     cfg_wdata,
    output uart_pkg::tick_t          cfg_rdata,
    uart_cfg_if.source               cfg
);
    import uart_pkg::*;

    tick_t divisor;
    tick_t bit_ticks;
    tick_t stop_ticks;
    logic  tx_enable;
    logic  rx_enable;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            divisor   <= DEFAULT_HALF_BIT_TICKS;
            tx_enable <= 1'b1;
            rx_enable <= 1'b1;
        end else if (cfg_we) begin
            if (cfg_addr == REG_DIVISOR) begin
                // A divisor below the minimum leaves no room for a half-bit wait
                if (cfg_wdata >= MIN_HALF_BIT_TICKS) begin
                    divisor <= cfg_wdata;
                end
            end else begin
                tx_enable <= cfg_wdata[CTRL_TX_ENABLE];
                rx_enable <= cfg_wdata[CTRL_RX_ENABLE];
            end
        end
    end

    // Derived counts follow the divisor one edge later
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bit_ticks  <= tick_t'(DEFAULT_HALF_BIT_TICKS << 1);
            stop_ticks <= stop_ticks_for(DEFAULT_HALF_BIT_TICKS);
        end else begin
            bit_ticks  <= tick_t'(divisor << 1);
            stop_ticks <= stop_ticks_for(divisor);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux and outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr == REG_DIVISOR) begin
            cfg_rdata = divisor;
        end else begin
            cfg_rdata[CTRL_TX_ENABLE] = tx_enable;
            cfg_rdata[CTRL_RX_ENABLE] = rx_enable;
        end
    end

    assign cfg.half_bit_ticks = divisor;
    assign cfg.bit_ticks      = bit_ticks;
    assign cfg.stop_ticks     = stop_ticks;
    assign cfg.tx_enable      = tx_enable;
    assign cfg.rx_enable      = rx_enable;

    // The receiver's start confirmation relies on this lower bound
    a_divisor_min: assert property (@(posedge clk) disable iff (!rstn)
        cfg.half_bit_ticks >= MIN_HALF_BIT_TICKS);

endmodule

`default_nettype wire

//--- uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            order,
    input  wire uart_pkg::byte_t write_data,
    output logic                 sendable,
    output logic                 txd,
    uart_cfg_if.sink             cfg
);
    import uart_pkg::*;

    tick_t      counter;
    tick_t      end_bit;
    tick_t      end_stop;
    logic       signal_bit;
    logic       signal_stop;
    logic       accept;
    logic [3:0] status;
    byte_t      txbuf;

    assign end_bit  = cfg.bit_ticks - 16'd1;
    assign end_stop = cfg.stop_ticks - 16'd1;

    // Orders that arrive while busy or disabled are simply dropped
    assign accept = (status == TX_IDLE) && order && cfg.tx_enable;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Restarting on accept keeps a stale end pulse out of the start bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter     <= '0;
            signal_bit  <= 1'b0;
            signal_stop <= 1'b0;
        end else begin
            if (accept || counter == end_bit) begin
                counter <= '0;
            end else begin
                counter <= counter + 16'd1;
            end
            signal_bit  <= !accept && (counter == end_bit);
            signal_stop <= !accept && (counter == end_stop);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            status   <= TX_IDLE;
            txd      <= 1'b1;
            sendable <= 1'b1;
        end else begin
            if (status == TX_IDLE) begin
                if (accept) begin
                    status   <= TX_START;
                    txd      <= 1'b0;
                    sendable <= 1'b0;
                end
            end else if (status == TX_STOP) begin
                if (signal_stop) begin
                    status   <= TX_IDLE;
                    txd      <= 1'b1;
                    sendable <= 1'b1;
                end
            end else if (signal_bit) begin
                if (status == TX_BIT7) begin
                    status <= TX_STOP;
                    txd    <= 1'b1;
                end else begin
                    status <= status + 4'd1;
                    txd    <= txbuf[0];
                end
            end
        end
    end

    // Data goes out LSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            txbuf <= write_data;
        end else if (signal_bit && status != TX_IDLE && status != TX_STOP) begin
            txbuf <= {1'b1, txbuf[7:1]};
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rstn)
        sendable |-> txd);

    // A frame starts only from idle, and the start bit shows on the next cycle
    a_accept_when_free: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> sendable ##1 (!sendable && !txd));

endmodule

`default_nettype wire

//--- uart_rx.sv
`default_nettype none

module uart_rx (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       rxd,
    output uart_pkg::byte_t rx_data,
    output logic            rx_valid,
    output logic            frame_error,
    uart_cfg_if.sink        cfg
);
    import uart_pkg::*;

    logic [1:0] sync;
    logic       rx_bit;
    rx_state_t  state;
    tick_t      counter;
    logic [2:0] bit_idx;
    logic       wait_high;
    logic       half_point;
    logic       bit_point;
    byte_t      shreg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Reset to the idle line level so no false start is seen
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], rxd};
        end
    end

    assign rx_bit     = sync[1];
    assign half_point = (counter == cfg.half_bit_ticks - 16'd1);
    assign bit_point  = (counter == cfg.bit_ticks - 16'd1);
    assign rx_data    = shreg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= RX_IDLE;
            counter     <= '0;
            bit_idx     <= '0;
            wait_high   <= 1'b0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            counter     <= counter + 16'd1;
            case (state)
                RX_IDLE: begin
                    counter <= '0;
                    if (!rx_bit && cfg.rx_enable) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // A line that is high again by mid start bit was only a glitch
                    if (half_point) begin
                        counter <= '0;
                        bit_idx <= '0;
                        state   <= rx_bit ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_point) begin
                        counter <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (wait_high) begin
                        if (rx_bit) begin
                            wait_high <= 1'b0;
                            state     <= RX_IDLE;
                        end
                    end else if (bit_point) begin
                        rx_valid    <= rx_bit;
                        frame_error <= !rx_bit;
                        if (rx_bit) begin
                            state <= RX_IDLE;
                        end else begin
                            wait_high <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Bits arrive LSB first, so the byte is complete after the eighth shift
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_point) begin
            shreg <= {rx_bit, shreg[7:1]};
        end
    end

    a_one_outcome: assert property (@(posedge clk) disable iff (!rstn)
        !(rx_valid && frame_error));

endmodule

`default_nettype wire

//--- uart_core.sv
`default_nettype none

module uart_core (
    input  wire logic                clk,
    input  wire logic                rstn,

    // Register port
    input  wire logic                cfg_we,
    input  wire uart_pkg::reg_addr_t cfg_addr,
    input  wire uart_pkg::tick_t     cfg_wdata,
    output uart_pkg::tick_t          cfg_rdata,

    // Transmit side
    input  wire logic                order,
    input  wire uart_pkg::byte_t     write_data,
    output logic                     sendable,
    output logic                     txd,

    // Receive side
    input  wire logic                rxd,
    output uart_pkg::byte_t          rx_data,
    output logic                     rx_valid,
    output logic                     frame_error
);

    uart_cfg_if cfg_bus ();

    uart_cfg_regs i_uart_cfg_regs (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg_bus.source)
    );

    uart_tx i_uart_tx (
        .clk        (clk),
        .rstn       (rstn),
        .order      (order),
        .write_data (write_data),
        .sendable   (sendable),
        .txd        (txd),
        .cfg        (cfg_bus.sink)
    );

    uart_rx i_uart_rx (
        .clk         (clk),
        .rstn        (rstn),
        .rxd         (rxd),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .frame_error (frame_error),
        .cfg         (cfg_bus.sink)
    );

endmodule

`default_nettype wire

//--- tb_uart_core.sv
`default_nettype none

module tb_uart_core;
    timeunit 1ns;
    timeprecision 1ps;
    import uart_pkg::*;

    logic      clk, rstn, cfg_we, order, sendable, txd, rxd, rx_valid, frame_error;
    reg_addr_t cfg_addr;
    tick_t     cfg_wdata, cfg_rdata;
    byte_t     write_data, rx_data, last_rx;

    // Register state as the testbench expects it
    int   half = int'(DEFAULT_HALF_BIT_TICKS);
    logic tx_en = 1'b1;
    logic rx_en = 1'b1;

    logic       loopback = 1'b1;
    logic       inj_line = 1'b1;
    int         valid_count = 0;
    int         ferr_count = 0;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;
    int         limit = 100000;
    int         seed = 32'h9a23_9399;
    logic [7:0] ops[$];
    int         arg_a[$];
    int         arg_b[$];

    assign rxd = loopback ? txd : inj_line;

    uart_core i_uart_core (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Receiver pulses are counted on the falling edge
    always @(negedge clk) begin
        if (rstn && rx_valid) begin
            valid_count <= valid_count + 1;
            last_rx     <= rx_data;
        end
        if (rstn && frame_error) begin
            ferr_count <= ferr_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and bus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("mismatch at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report(input int num, input string what, input int errors0);
        if (errors == errors0) begin
            $display("test %0d %s: ok", num, what);
        end else begin
            $display("test %0d %s: FAILED", num, what);
        end
    endtask

    task automatic write_reg(input int addr, input int data);
        cfg_we = 1'b1;
        cfg_addr = addr[0];
        cfg_wdata = data[15:0];
        @(negedge clk);
        cfg_we = 1'b0;
        // The derived bit counts follow the divisor one edge later
        @(negedge clk);
        if (addr[0] == REG_DIVISOR) begin
            if (data >= int'(MIN_HALF_BIT_TICKS)) begin
                half = data;
            end
        end else begin
            tx_en = data[0];
            rx_en = data[1];
        end
    endtask

    task automatic read_reg(input int addr, input int expected);
        cfg_addr = addr[0];
        @(negedge clk);
        compare((addr[0] == REG_DIVISOR) ? "divisor" : "control", expected, int'(cfg_rdata));
    endtask

    // Waits up to one bit time for a receiver pulse, then checks what arrived
    task automatic expect_rx(input int valid0, input int ferr0, input logic want_valid,
                             input logic want_ferr, input byte_t data);
        int n;
        n = 0;
        while (valid_count == valid0 && ferr_count == ferr0 && n < 2 * half) begin
            @(negedge clk);
            n++;
        end
        compare("rx_valid pulses", int'(want_valid), valid_count - valid0);
        compare("frame_error pulses", int'(want_ferr), ferr_count - ferr0);
        if (want_valid) begin
            compare("rx_data", int'(data), int'(last_rx));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_byte(input byte_t data, input logic busy);
        int   valid0;
        int   ferr0;
        int   n;
        logic expected;
        valid0 = valid_count;
        ferr0 = ferr_count;
        order = 1'b1;
        write_data = data;
        @(negedge clk);
        order = 1'b0;
        if (!tx_en) begin
            repeat (4 * half) @(negedge clk);
            compare("txd", 1, int'(txd));
            compare("sendable", 1, int'(sendable));
        end else begin
            compare("sendable", 0, int'(sendable));
            // Each bit is sampled near its middle, counted from the falling start edge
            for (int k = 0; k < 10; k++) begin
                repeat ((k == 0) ? half : 2 * half) begin
                    @(negedge clk);
                    order = 1'b0;
                end
                if (k == 0) begin
                    expected = 1'b0;
                end else if (k == 9) begin
                    expected = 1'b1;
                end else begin
                    expected = data[k - 1];
                end
                compare("txd", int'(expected), int'(txd));
                // A second order in mid frame has to be dropped
                if (busy && k == 4) begin
                    order = 1'b1;
                    write_data = ~data;
                end
            end
            compare("sendable", 0, int'(sendable));
            n = 0;
            while (!sendable && n < 4 * half) begin
                @(negedge clk);
                n++;
            end
            if (!sendable) begin
                $display("Error at time %0t: sendable stayed low after the stop bit", $time);
                errors++;
            end
        end
        expect_rx(valid0, ferr0, tx_en && rx_en, 1'b0, data);
        if (busy) begin
            repeat (2 * half) @(negedge clk);
            compare("txd", 1, int'(txd));
            compare("rx_valid pulses", int'(tx_en && rx_en), valid_count - valid0);
        end
    endtask

    task automatic inject_frame(input byte_t data, input logic stop_bit);
        int valid0;
        int ferr0;
        valid0 = valid_count;
        ferr0 = ferr_count;
        loopback = 1'b0;
        for (int k = 0; k < 10; k++) begin
            if (k == 0) begin
                inj_line = 1'b0;
            end else if (k == 9) begin
                inj_line = stop_bit;
            end else begin
                inj_line = data[k - 1];
            end
            repeat (2 * half) @(negedge clk);
        end
        inj_line = 1'b1;
        expect_rx(valid0, ferr0, rx_en && stop_bit, rx_en && !stop_bit, data);
        // Idle line lets the receiver leave its stop state
        repeat (2 * half) @(negedge clk);
        loopback = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          fd, a, b, frames, max_half, errors0;
        string       line;
        logic [7:0]  op;
        logic [31:0] rnd;
        rstn = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = REG_DIVISOR;
        cfg_wdata = '0;
        order = 1'b0;
        write_data = '0;
        frames = 0;
        max_half = int'(DEFAULT_HALF_BIT_TICKS);
        fd = $fopen("uart_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Error: could not open uart_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != "#") begin
                    void'($sscanf(line, "%c %h %h", op, a, b));
                    ops.push_back(op);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    if (op == "S" || op == "I") begin
                        frames++;
                    end else if (op == "M") begin
                        frames += a;
                    end else if (op == "W" && a == 0 && b > max_half) begin
                        max_half = b;
                    end
                end
            end
            $fclose(fd);
        end
        // A frame with its checks takes at most 12 bit times at the slowest divisor
        limit = frames * 12 * 2 * max_half + ops.size() * 16 + 200;

        repeat (2) @(negedge clk);
        rstn = 1'b1;
        errors0 = errors;
        @(negedge clk);
        compare("txd", 1, int'(txd));
        compare("sendable", 1, int'(sendable));
        compare("rx_valid", 0, int'(rx_valid));
        compare("frame_error", 0, int'(frame_error));
        report(0, "reset", errors0);

        for (int i = 0; i < ops.size(); i++) begin
            errors0 = errors;
            op = ops[i];
            a = arg_a[i];
            b = arg_b[i];
            case (op)
                "W": write_reg(a, b);
                "R": read_reg(a, b);
                "S": send_byte(a[7:0], b[0]);
                "I": inject_frame(a[7:0], b[0]);
                "M": begin
                    for (int j = 0; j < a; j++) begin
                        rnd = $random(seed);
                        send_byte(rnd[7:0], 1'b0);
                    end
                end
                default: begin
                    $display("Error: unknown command %c in the stimulus file", op);
                    errors++;
                end
            endcase
            report(i + 1, $sformatf("%c %0h %0h", op, a, b), errors0);
        end

        $display("%0d tests, %0d checks, %0d errors", ops.size() + 1, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_stimulus.txt
# op a b, values in hex: W addr data, R addr expected, S byte busy_order,
# I byte stop_bit (drives rxd directly), M count 0 (random bytes in loopback)
R 0 0008
R 1 0003
S a5 0
S 3c 1
W 0 0001
R 0 0008
W 0 0003
R 0 0003
S 96 0
M 4 0
I 5a 0
I c3 1
W 1 0002
R 1 0002
S 0f 0
W 1 0001
R 1 0001
I 81 1
S 7e 0
W 1 0003
W 0 0002
S e1 0

//--- filelist.f
uart_pkg.sv
uart_cfg_if.sv
uart_cfg_regs.sv
uart_tx.sv
uart_rx.sv
uart_core.sv
tb_uart_core.sv

//--- Makefile
TOP = tb_uart_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module uart_core -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
